//--- hw/proc_settings.svh
// core settings giving the data width and the memory depths
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// data and instruction width
`define PROC_XLEN 32

// instruction memory depth in words
`define PROC_IMEM_WORDS 64

// data memory depth in words
`define PROC_DMEM_WORDS 64

`endif

//--- hw/isa_pkg.sv
// isa package with word types, opcode and funct constants and field helpers
`include "proc_settings.svh"

package isa_pkg;
	typedef logic [`PROC_XLEN-1:0] data_t;
	typedef logic [`PROC_XLEN-1:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [$clog2(`PROC_IMEM_WORDS)-1:0] imem_addr_t;

	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_WORD = 3'b010;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	localparam instr_t INSTR_EBREAK = {12'h001, 5'd0, 3'b000, 5'd0, OP_SYSTEM};
	// addi x0,x0,0
	localparam instr_t INSTR_NOP = {12'h000, 5'd0, F3_ADD, 5'd0, OP_IMM};

	function automatic logic [6:0] opcode_of(instr_t i);
		return i[6:0];
	endfunction

	function automatic logic [2:0] funct3_of(instr_t i);
		return i[14:12];
	endfunction

	function automatic logic [6:0] funct7_of(instr_t i);
		return i[31:25];
	endfunction

	function automatic reg_addr_t rd_of(instr_t i);
		return i[11:7];
	endfunction

	function automatic reg_addr_t rs1_of(instr_t i);
		return i[19:15];
	endfunction

	function automatic reg_addr_t rs2_of(instr_t i);
		return i[24:20];
	endfunction
endpackage

//--- hw/pipe_pkg.sv
// pipeline control package with forwarding selects and the ebreak halt states
package pipe_pkg;
	typedef logic [1:0] fwd_sel_t;

	localparam fwd_sel_t FWD_REG   = 2'd0;
	localparam fwd_sel_t FWD_EXMEM = 2'd1;
	localparam fwd_sel_t FWD_MEMWB = 2'd2;

	typedef enum logic [2:0] {
		EBK_IDLE,
		EBK_DRAIN_1,
		EBK_DRAIN_2,
		EBK_DRAIN_3,
		// parked until the debugger resumes
		EBK_WAIT
	} ebreak_state_t;

	// operand mux shared by decode and execute
	function automatic isa_pkg::data_t fwd_pick(fwd_sel_t sel, isa_pkg::data_t reg_val,
			isa_pkg::data_t exmem_val, isa_pkg::data_t memwb_val);
		case (sel)
			FWD_EXMEM: return exmem_val;
			FWD_MEMWB: return memwb_val;
			default:   return reg_val;
		endcase
	endfunction
endpackage

//--- hw/pipe_ifs.sv
// stage-to-stage pipeline register interfaces for IF/ID, ID/EX and EX/MEM
`timescale 1ns/1ps

interface fd_if;
	import isa_pkg::*;

	data_t  pc;
	instr_t instr;

	modport src (output pc, instr);
	modport dst (input pc, instr);
	modport mon (input instr);
endinterface

interface dx_if;
	import isa_pkg::*;

	instr_t instr;
	data_t  pc;
	data_t  rs1_val;
	data_t  rs2_val;
	data_t  imm;
	logic   rd_wren;

	modport src (output instr, pc, rs1_val, rs2_val, imm, rd_wren);
	modport dst (input instr, pc, rs1_val, rs2_val, imm, rd_wren);
	modport mon (input instr, rd_wren);
endinterface

interface xm_if;
	import isa_pkg::*;

	instr_t instr;
	data_t  alu_result;
	data_t  store_data;
	logic   rd_wren;

	modport src (output instr, alu_result, store_data, rd_wren);
	modport dst (input instr, alu_result, store_data, rd_wren);
	// rd comes from the instr field
	modport mon (input instr, alu_result, rd_wren);
endinterface

//--- hw/fetch.sv
// fetch stage with PC, loadable instruction memory and the IF/ID register
`timescale 1ns/1ps
`include "proc_settings.svh"

module fetch (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                imem_wren,
	input  isa_pkg::imem_addr_t imem_addr,
	input  isa_pkg::instr_t     imem_wdata,
	input  logic                stall,
	input  logic                flush,
	input  logic                pc_sel,
	input  isa_pkg::data_t      pc_bj,
	fd_if.src                   fd
);
	import isa_pkg::*;

	localparam int IMEM_AW = $bits(imem_addr_t);

	instr_t imem [`PROC_IMEM_WORDS];
	data_t  pc;
	data_t  pc_next;
	instr_t fetched;

	// program load port
	always_ff @(posedge clk) begin
		if (imem_wren)
			imem[imem_addr] <= imem_wdata;
	end

	assign fetched = imem[pc[IMEM_AW+1:2]];
	// not-taken is always assumed
	assign pc_next = pc_sel ? pc_bj : pc + data_t'(4);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= '0;
			fd.instr <= INSTR_NOP;
		end else begin
			if (!stall)
				pc <= pc_next;
			if (flush)
				fd.instr <= INSTR_NOP;
			else if (!stall)
				fd.instr <= fetched;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall)
			fd.pc <= pc;
	end

	// decode drops a taken branch whenever the front end is held
	a_no_redirect_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(pc_sel && stall));

endmodule : fetch

//--- hw/decode.sv
// decode stage with register file, immediates, branch resolve and the ID/EX register
`timescale 1ns/1ps
`include "proc_settings.svh"

module decode (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               stall,
	input  pipe_pkg::fwd_sel_t fwd_rs1,
	input  pipe_pkg::fwd_sel_t fwd_rs2,
	input  logic               wb_wren,
	input  isa_pkg::reg_addr_t wb_addr,
	input  isa_pkg::data_t     wb_data,
	fd_if.dst                  fd,
	dx_if.src                  dx,
	xm_if.mon                  xm,
	output logic               pc_sel,
	output isa_pkg::data_t     pc_bj,
	output logic               decode_ebreak
);
	import isa_pkg::*;
	import pipe_pkg::*;

	data_t rf [1:31];
	data_t rs1_val, rs2_val;
	data_t br_a, br_b;
	data_t imm_i, imm_s, imm_b;
	logic  is_add, is_sub, is_addi, is_lw, is_sw, is_beq;
	logic  passes_on, writes_rd;

	// write-through read, x0 reads zero
	function automatic data_t rf_read(reg_addr_t a);
		if (a == '0)
			return '0;
		if (wb_wren && wb_addr == a)
			return wb_data;
		return rf[a];
	endfunction

	always_ff @(posedge clk) begin
		if (wb_wren && wb_addr != '0)
			rf[wb_addr] <= wb_data;
	end

	assign is_add  = opcode_of(fd.instr) == OP_REG && funct3_of(fd.instr) == F3_ADD
		&& funct7_of(fd.instr) == '0;
	assign is_sub  = opcode_of(fd.instr) == OP_REG && funct3_of(fd.instr) == F3_ADD
		&& funct7_of(fd.instr) == F7_SUB;
	assign is_addi = opcode_of(fd.instr) == OP_IMM && funct3_of(fd.instr) == F3_ADD;
	assign is_lw   = opcode_of(fd.instr) == OP_LOAD && funct3_of(fd.instr) == F3_WORD;
	assign is_sw   = opcode_of(fd.instr) == OP_STORE && funct3_of(fd.instr) == F3_WORD;
	assign is_beq  = opcode_of(fd.instr) == OP_BRANCH && funct3_of(fd.instr) == F3_BEQ;

	// anything unsupported leaves decode as a nop
	assign passes_on = is_add || is_sub || is_addi || is_lw || is_sw;
	assign writes_rd = (is_add || is_sub || is_addi || is_lw) && rd_of(fd.instr) != '0;

	assign imm_i = {{(`PROC_XLEN-12){fd.instr[31]}}, fd.instr[31:20]};
	assign imm_s = {{(`PROC_XLEN-12){fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
	assign imm_b = {{(`PROC_XLEN-13){fd.instr[31]}}, fd.instr[31], fd.instr[7],
		fd.instr[30:25], fd.instr[11:8], 1'b0};

	assign rs1_val = rf_read(rs1_of(fd.instr));
	assign rs2_val = rf_read(rs2_of(fd.instr));

	// beq compare on forwarded operands
	assign br_a = fwd_pick(fwd_rs1, rs1_val, xm.alu_result, wb_data);
	assign br_b = fwd_pick(fwd_rs2, rs2_val, xm.alu_result, wb_data);
	assign pc_sel = is_beq && br_a == br_b && !stall;
	assign pc_bj = fd.pc + imm_b;
	assign decode_ebreak = fd.instr == INSTR_EBREAK;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx.instr   <= INSTR_NOP;
			dx.rd_wren <= 1'b0;
		end else if (stall) begin
			dx.instr   <= INSTR_NOP;
			dx.rd_wren <= 1'b0;
		end else begin
			dx.instr   <= passes_on ? fd.instr : INSTR_NOP;
			dx.rd_wren <= writes_rd;
		end
	end

	always_ff @(posedge clk) begin
		dx.pc      <= fd.pc;
		dx.rs1_val <= rs1_val;
		dx.rs2_val <= rs2_val;
		dx.imm     <= is_sw ? imm_s : imm_i;
	end

	a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
		wb_wren |-> wb_addr != '0);

endmodule : decode

//--- hw/execute.sv
// execute stage with operand forwarding, add/sub ALU and the EX/MEM register
`timescale 1ns/1ps

module execute (
	input  logic               clk,
	input  logic               rst_n,
	input  pipe_pkg::fwd_sel_t fwd_a,
	input  pipe_pkg::fwd_sel_t fwd_b,
	input  isa_pkg::data_t     wb_data,
	dx_if.dst                  dx,
	xm_if.src                  xm
);
	import isa_pkg::*;
	import pipe_pkg::*;

	data_t op_a;
	data_t rs2_fwd;
	data_t op_b;
	data_t result;

	assign op_a    = fwd_pick(fwd_a, dx.rs1_val, xm.alu_result, wb_data);
	assign rs2_fwd = fwd_pick(fwd_b, dx.rs2_val, xm.alu_result, wb_data);

	// register ops take rs2, addi and load/store address take the immediate
	always_comb begin
		op_b = (opcode_of(dx.instr) == OP_REG) ? rs2_fwd : dx.imm;
		if (opcode_of(dx.instr) == OP_REG && funct7_of(dx.instr) == F7_SUB)
			result = op_a - op_b;
		else
			result = op_a + op_b;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xm.instr   <= INSTR_NOP;
			xm.rd_wren <= 1'b0;
		end else begin
			xm.instr   <= dx.instr;
			// already limited to add, sub, addi and lw in decode
			xm.rd_wren <= dx.rd_wren;
		end
	end

	always_ff @(posedge clk) begin
		xm.alu_result <= result;
		xm.store_data <= rs2_fwd;
	end

	// branch targets from decode must stay word aligned
	a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		dx.instr != INSTR_NOP |-> dx.pc[1:0] == 2'b00);

endmodule : execute

//--- hw/hazard_ctrl.sv
// hazard unit giving forwarding selects, load-use and branch stalls and branch flush
`timescale 1ns/1ps

module hazard_ctrl (
	fd_if.mon                  fd,
	dx_if.mon                  dx,
	xm_if.mon                  xm,
	input  logic               wb_wren,
	input  isa_pkg::reg_addr_t wb_addr,
	input  logic               pc_sel,
	output pipe_pkg::fwd_sel_t fwd_a,
	output pipe_pkg::fwd_sel_t fwd_b,
	output pipe_pkg::fwd_sel_t fwd_rs1,
	output pipe_pkg::fwd_sel_t fwd_rs2,
	output logic               stall_fd,
	output logic               flush_fd
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic hit_dx, hit_xm;
	logic load_use, branch_wait, fd_beq;

	// newest producer wins, x0 is never forwarded
	function automatic fwd_sel_t pick_src(reg_addr_t rs);
		if (rs == '0)
			return FWD_REG;
		if (xm.rd_wren && rd_of(xm.instr) == rs)
			return FWD_EXMEM;
		if (wb_wren && wb_addr == rs)
			return FWD_MEMWB;
		return FWD_REG;
	endfunction

	// does consumer read the register that producer writes
	function automatic logic reads_rd(instr_t cons, instr_t prod);
		logic [6:0] op;
		logic       use1, use2;
		op   = opcode_of(cons);
		use1 = op inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE, OP_BRANCH};
		use2 = op inside {OP_REG, OP_STORE, OP_BRANCH};
		return (use1 && rs1_of(cons) == rd_of(prod)) || (use2 && rs2_of(cons) == rd_of(prod));
	endfunction

	assign fwd_a   = pick_src(rs1_of(dx.instr));
	assign fwd_b   = pick_src(rs2_of(dx.instr));
	assign fwd_rs1 = pick_src(rs1_of(fd.instr));
	assign fwd_rs2 = pick_src(rs2_of(fd.instr));

	assign hit_dx = dx.rd_wren && reads_rd(fd.instr, dx.instr);
	assign hit_xm = xm.rd_wren && reads_rd(fd.instr, xm.instr);
	assign fd_beq = opcode_of(fd.instr) == OP_BRANCH && funct3_of(fd.instr) == F3_BEQ;

	assign load_use = hit_dx && opcode_of(dx.instr) == OP_LOAD;
	// a load in MEM only holds its address, so beq waits one more cycle
	assign branch_wait = fd_beq && (hit_dx || (hit_xm && opcode_of(xm.instr) == OP_LOAD));

	assign stall_fd = load_use || branch_wait;
	assign flush_fd = pc_sel;

	always_comb begin
		assert (!(stall_fd && flush_fd));
	end

endmodule : hazard_ctrl

//--- hw/mem_wb.sv
// memory and write-back stage with data memory, MEM/WB register and retire port
`timescale 1ns/1ps
`include "proc_settings.svh"

module mem_wb (
	input  logic               clk,
	input  logic               rst_n,
	xm_if.dst                  xm,
	output logic               wb_wren,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::data_t     wb_data,
	output logic               retire_valid,
	output isa_pkg::reg_addr_t retire_rd,
	output isa_pkg::data_t     retire_data
);
	import isa_pkg::*;

	localparam int DMEM_AW = $clog2(`PROC_DMEM_WORDS);

	data_t              dmem [`PROC_DMEM_WORDS];
	logic [DMEM_AW-1:0] word_idx;
	data_t              load_data;

	// word addressed, low two bits ignored
	assign word_idx  = xm.alu_result[DMEM_AW+1:2];
	assign load_data = dmem[word_idx];

	always_ff @(posedge clk) begin
		if (opcode_of(xm.instr) == OP_STORE)
			dmem[word_idx] <= xm.store_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_wren <= 1'b0;
		else
			wb_wren <= xm.rd_wren;
	end

	// write-back value picked before the register
	always_ff @(posedge clk) begin
		wb_addr <= rd_of(xm.instr);
		wb_data <= (opcode_of(xm.instr) == OP_LOAD) ? load_data : xm.alu_result;
	end

	// trace out every register write
	assign retire_valid = wb_wren;
	assign retire_rd    = wb_addr;
	assign retire_data  = wb_data;

endmodule : mem_wb

//--- hw/proc.sv
// processor top joining the five pipeline stages and the ebreak halt FSM
`timescale 1ns/1ps

module proc (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                imem_wren,
	input  isa_pkg::imem_addr_t imem_addr,
	input  isa_pkg::instr_t     imem_wdata,
	input  logic                ebreak_return,
	output logic                retire_valid,
	output isa_pkg::reg_addr_t  retire_rd,
	output isa_pkg::data_t      retire_data,
	output logic                ebreak_start
);
	import isa_pkg::*;
	import pipe_pkg::*;

	fd_if fd_bus ();
	dx_if dx_bus ();
	xm_if xm_bus ();

	logic          wb_wren;
	reg_addr_t     wb_addr;
	data_t         wb_data;
	logic          pc_sel, decode_ebreak;
	data_t         pc_bj;
	fwd_sel_t      fwd_a, fwd_b, fwd_rs1, fwd_rs2;
	logic          stall_fd, flush_fd;
	logic          halt_stall, resume_flush;
	ebreak_state_t ebk_state, ebk_next;

	fetch fetch_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_wren  (imem_wren),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.stall      (stall_fd | halt_stall),
		.flush      (flush_fd | resume_flush),
		.pc_sel     (pc_sel),
		.pc_bj      (pc_bj),
		.fd         (fd_bus.src)
	);

	decode decode_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall         (stall_fd | halt_stall),
		.fwd_rs1       (fwd_rs1),
		.fwd_rs2       (fwd_rs2),
		.wb_wren       (wb_wren),
		.wb_addr       (wb_addr),
		.wb_data       (wb_data),
		.fd            (fd_bus.dst),
		.dx            (dx_bus.src),
		.xm            (xm_bus.mon),
		.pc_sel        (pc_sel),
		.pc_bj         (pc_bj),
		.decode_ebreak (decode_ebreak)
	);

	execute execute_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.fwd_a   (fwd_a),
		.fwd_b   (fwd_b),
		.wb_data (wb_data),
		.dx      (dx_bus.dst),
		.xm      (xm_bus.src)
	);

	hazard_ctrl hazard_ctrl_i (
		.fd       (fd_bus.mon),
		.dx       (dx_bus.mon),
		.xm       (xm_bus.mon),
		.wb_wren  (wb_wren),
		.wb_addr  (wb_addr),
		.pc_sel   (pc_sel),
		.fwd_a    (fwd_a),
		.fwd_b    (fwd_b),
		.fwd_rs1  (fwd_rs1),
		.fwd_rs2  (fwd_rs2),
		.stall_fd (stall_fd),
		.flush_fd (flush_fd)
	);

	mem_wb mem_wb_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.xm           (xm_bus.dst),
		.wb_wren      (wb_wren),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.retire_valid (retire_valid),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ebk_state <= EBK_IDLE;
		else
			ebk_state <= ebk_next;
	end

	// three drain cycles let the older instructions retire
	always_comb begin
		ebk_next = ebk_state;
		case (ebk_state)
			EBK_IDLE:    if (decode_ebreak) ebk_next = EBK_DRAIN_1;
			EBK_DRAIN_1: ebk_next = EBK_DRAIN_2;
			EBK_DRAIN_2: ebk_next = EBK_DRAIN_3;
			EBK_DRAIN_3: ebk_next = EBK_WAIT;
			EBK_WAIT:    if (ebreak_return) ebk_next = EBK_IDLE;
			default:     ebk_next = EBK_IDLE;
		endcase
	end

	// ebreak stays parked in IF/ID until resume flushes it, PC held on that cycle
	assign halt_stall   = decode_ebreak || ebk_state != EBK_IDLE;
	assign resume_flush = ebk_state == EBK_WAIT && ebreak_return;
	assign ebreak_start = ebk_state == EBK_WAIT;

	a_return_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		ebreak_return |-> ebk_state == EBK_WAIT);

endmodule : proc

//--- sim/tb_proc.sv
// testbench for the proc core, runs a program from a data file and checks the retire trace
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);
	localparam int HALF_NS = 50;

	initial clk = 1'b0;

	always #(HALF_NS) clk = ~clk;

endmodule : tb_clock

module tb_proc;
	import isa_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int IDLE_CYCLES  = 10;
	localparam int MARGIN       = 20;

	logic       clk;
	logic       rst_n;
	logic       imem_wren;
	imem_addr_t imem_addr;
	instr_t     imem_wdata;
	logic       ebreak_return;
	logic       retire_valid;
	reg_addr_t  retire_rd;
	data_t      retire_data;
	logic       ebreak_start;

	instr_t    prog[$];
	reg_addr_t exp_rd[$];
	data_t     exp_data[$];
	int        ebk_points[$];
	int        waits[$];
	int        retire_count = 0;
	int        since_retire = 0;
	int        ebk_idx = 0;
	int        limit_cycles = 0;
	int        sum_wait = 0;

	tb_clock clock_gen (.clk(clk));

	proc proc_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.imem_wren     (imem_wren),
		.imem_addr     (imem_addr),
		.imem_wdata    (imem_wdata),
		.ebreak_return (ebreak_return),
		.retire_valid  (retire_valid),
		.retire_rd     (retire_rd),
		.retire_data   (retire_data),
		.ebreak_start  (ebreak_start)
	);

	task automatic end_in_failure();
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_problem(input string what);
		$display("%s (at %0t ns)", what, $time);
		end_in_failure();
	endtask

	task automatic check_value(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			end_in_failure();
		end
	endtask

	// reads P, E and R records and skips # comment lines
	task automatic read_testdata();
		int     fh;
		int     n;
		int     rd;
		string  line;
		string  rest;
		instr_t word;
		data_t  val;
		fh = $fopen("sim/proc_testdata.txt", "r");
		if (fh == 0)
			report_problem("cannot open sim/proc_testdata.txt");
		while (!$feof(fh)) begin
			line = "";
			n = $fgets(line, fh);
			if (n == 0 || line.len() < 3)
				continue;
			rest = line.substr(1, line.len() - 1);
			case (line.getc(0))
				"P": begin
					n = $sscanf(rest, "%h", word);
					prog.push_back(word);
				end
				"E": begin
					n = $sscanf(rest, "%d %h", rd, val);
					exp_rd.push_back(reg_addr_t'(rd));
					exp_data.push_back(val);
				end
				"R": begin
					n = $sscanf(rest, "%d", rd);
					ebk_points.push_back(rd);
				end
				"#": ;
				default: report_problem("test data holds a line of unknown kind");
			endcase
		end
		$fclose(fh);
		if (prog.size() == 0 || prog.size() > 2 ** $bits(imem_addr_t))
			report_problem("program in test data is empty or too large for instruction memory");
	endtask

	// one word per cycle with the core held in reset
	task automatic load_program();
		foreach (prog[i]) begin
			@(posedge clk);
			imem_wren  <= 1'b1;
			imem_addr  <= imem_addr_t'(i);
			imem_wdata <= prog[i];
		end
		@(posedge clk);
		imem_wren <= 1'b0;
	endtask

	task automatic resume_after_ebreak(input int k);
		do
			@(negedge clk);
		while (!ebreak_start);
		repeat (waits[k]) @(posedge clk);
		ebreak_return <= 1'b1;
		ebk_idx       <= ebk_idx + 1;
		@(posedge clk);
		ebreak_return <= 1'b0;
		@(negedge clk);
		check_value("ebreak_start", data_t'(ebreak_start), '0);
	endtask

	// retire trace monitor sampled away from the driving edge
	always @(negedge clk) begin
		if (!rst_n) begin
			check_value("retire_valid", data_t'(retire_valid), '0);
			check_value("ebreak_start", data_t'(ebreak_start), '0);
		end else begin
			if (retire_valid) begin
				if (ebreak_start)
					report_problem("a register retired while the core was halted");
				else if (exp_rd.size() == 0)
					report_problem("a register retired after the last expected record");
				else begin
					check_value("retire_rd", data_t'(retire_rd), data_t'(exp_rd.pop_front()));
					check_value("retire_data", retire_data, exp_data.pop_front());
					retire_count++;
					since_retire = 0;
				end
			end else begin
				since_retire++;
			end
			// halt must follow the last older retire quickly
			if (ebk_idx < ebk_points.size() && retire_count == ebk_points[ebk_idx]
					&& !ebreak_start && since_retire >= 6)
				report_problem("ebreak_start did not rise within 6 cycles of the last retire");
		end
	end

	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		report_problem("watchdog expired before the test finished");
	end

	initial begin
		rst_n         = 1'b0;
		imem_wren     = 1'b0;
		imem_addr     = '0;
		imem_wdata    = '0;
		ebreak_return = 1'b0;
		void'($urandom(83747));
		read_testdata();
		foreach (ebk_points[k]) begin
			waits.push_back(1 + ($urandom % 12));
			sum_wait += waits[k];
		end
		limit_cycles = (prog.size() + RESET_CYCLES + sum_wait) * MARGIN;

		load_program();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("retire_valid", data_t'(retire_valid), '0);
		check_value("ebreak_start", data_t'(ebreak_start), '0);

		foreach (ebk_points[k])
			resume_after_ebreak(k);

		do
			@(posedge clk);
		while (exp_rd.size() != 0);
		// the spin loop at the end must stay silent
		repeat (IDLE_CYCLES) @(negedge clk);

		$display("Simulation PASSED");
		$finish;
	end

endmodule : tb_proc

//--- proc.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/pipe_ifs.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/hazard_ctrl.sv
hw/mem_wb.sv
hw/proc.sv
sim/tb_proc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the proc testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_proc \
	-f proc.f -o tb_proc_sim; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_proc_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Simulation FAILED" "$log"; then
	echo "result: fail"
	exit 1
fi
if [ "$run_status" -ne 0 ]; then
	echo "result: simulator exited with status $run_status"
	exit 1
fi
if ! grep -q "Simulation PASSED" "$log"; then
	echo "result: no pass line in $log"
	exit 1
fi
echo "result: pass"
exit 0

//--- sim/proc_testdata.txt
# P <instruction word hex> loads instruction memory from word 0, E <rd> <value hex> is a retire
# R <retires seen before the ebreak halts the core>, one line per ebreak in program order
P 00500093  addi x1, x0, 5
P 00708113  addi x2, x1, 7
P 002081b3  add  x3, x1, x2
P 40118233  sub  x4, x3, x1
P 003202b3  add  x5, x4, x3
P 00502423  sw   x5, 8(x0)
P 00802303  lw   x6, 8(x0)
P 005303b3  add  x7, x6, x5
P 00738463  beq  x7, x7, +8
P 06300413  addi x8, x0, 99
P 00100493  addi x9, x0, 1
P 00048463  beq  x9, x0, +8
P 00248513  addi x10, x9, 2
P 00100073  ebreak
P 00450593  addi x11, x10, 4
P 00802603  lw   x12, 8(x0)
P 00660463  beq  x12, x6, +8
P 00100693  addi x13, x0, 1
P 40b606b3  sub  x13, x12, x11
P 00100073  ebreak
P 00d68733  add  x14, x13, x13
P 00000063  beq  x0, x0, 0
E 1 00000005
E 2 0000000c
E 3 00000011
E 4 0000000c
E 5 0000001d
E 6 0000001d
E 7 0000003a
E 9 00000001
E 10 00000003
E 11 00000007
E 12 0000001d
E 13 00000016
E 14 0000002c
R 9
R 12
